/* cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// word and address widths of both RAMs.
`define DATA_WIDTH 8
`define ADDR_WIDTH 8

// words per RAM.
`define RAM_DEPTH 256

// each core owns 2**REGION_BITS words of the data RAM.
`define REGION_BITS 7

// immediate or offset field at the bottom of an instruction.
`define OPERAND_BITS 5

`endif

/* memBusPkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package memBusPkg;

	typedef logic [`DATA_WIDTH-1:0] dataWord;     // ram word and accumulator.
	typedef logic [`ADDR_WIDTH-1:0] memAddress;   // address into either ram.
	typedef logic [0:0] requesterIndex;           // arbiter port, also the core id.

endpackage

`default_nettype wire

/* coreIsaPkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package coreIsaPkg;

	// opcode sits in the top bits of the instruction word.
	typedef enum logic [`DATA_WIDTH-`OPERAND_BITS-1:0] {
		opLoadImm,
		opAddImm,
		opLoad,
		opStore,
		opAddMem,
		opXorMem,
		opJumpNotZero,
		opHalt
	} opcode;

	typedef logic [`OPERAND_BITS-1:0] operandField;

	typedef enum logic [2:0] {
		idle,
		fetch,
		execute,
		memory,
		halted
	} coreState;

endpackage

`default_nettype wire

/* syncRam.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_defs.svh"

module syncRam (
	input wire clk,
	input wire writeEnable,
	input wire memBusPkg::memAddress writeAddress,
	input wire memBusPkg::dataWord writeData,
	input wire readEnable,
	input wire memBusPkg::memAddress readAddress,
	output memBusPkg::dataWord readData
);

	import memBusPkg::*;

	dataWord mem [`RAM_DEPTH];

	initial begin
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// nonblocking on both sides, so a colliding read sees the old word.
	always_ff @(posedge clk) begin
		if (writeEnable) begin
			mem[writeAddress] <= writeData;
		end
		if (readEnable) begin
			readData <= mem[readAddress];   // held while not reading.
		end
	end

endmodule

`default_nettype wire

/* memArbiter.sv */
`default_nettype none
`timescale 1ns/10ps

module memArbiter (
	input wire clk,
	input wire reset,
	input wire [1:0] requestRead,
	input wire [1:0] requestWrite,
	input wire memBusPkg::memAddress [1:0] requestAddress,
	input wire memBusPkg::dataWord [1:0] requestData,
	output logic [1:0] ack,
	output memBusPkg::dataWord readData,
	output logic [1:0] grant,
	output logic ramRead,
	output logic ramWrite,
	output memBusPkg::memAddress ramAddress,
	output memBusPkg::dataWord ramWriteData,
	input wire memBusPkg::dataWord ramReadData
);

	import memBusPkg::*;

	typedef enum logic [1:0] {
		arbIdle,
		arbAccess,
		arbRespond
	} arbState;

	arbState state;
	requesterIndex lastWinner;   // also the owner while a grant is held.
	requesterIndex winner;
	logic [1:0] pending;

	assign pending = requestRead | requestWrite;

	// the port not served last goes first when both ask.
	always_comb begin
		if (pending[0] && pending[1]) begin
			winner = ~lastWinner;
		end else if (pending[1]) begin
			winner = 1'b1;
		end else begin
			winner = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arbIdle;
			grant <= '0;
			lastWinner <= 1'b1;   // port 0 first after reset.
		end else begin
			case (state)
				arbIdle: begin
					if (|pending) begin
						state <= arbAccess;
						grant <= 2'b01 << winner;
						lastWinner <= winner;
					end
				end
				arbAccess: begin
					state <= arbRespond;   // ram registers the read here.
				end
				arbRespond: begin
					state <= arbIdle;
					grant <= '0;
				end
				default: begin
					state <= arbIdle;
					grant <= '0;
				end
			endcase
		end
	end

	assign ramRead = (state == arbAccess) && requestRead[lastWinner];
	assign ramWrite = (state == arbAccess) && requestWrite[lastWinner];
	assign ramAddress = requestAddress[lastWinner];
	assign ramWriteData = requestData[lastWinner];

	assign ack = (state == arbRespond) ? grant : 2'b00;
	assign readData = ramReadData;   // valid in the ack cycle.

	grantOneHot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

	// requesters must hold their request until the ack arrives.
	ackOnlyToRequester: assert property (@(posedge clk) disable iff (reset)
		(ack & ~pending) == 2'b00);

endmodule

`default_nettype wire

/* core.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_defs.svh"

module core #(
	parameter memBusPkg::requesterIndex coreId = '0
) (
	input wire clk,
	input wire reset,
	input wire start,
	output logic instrRead,
	output memBusPkg::memAddress instrAddress,
	input wire instrAck,
	input wire memBusPkg::dataWord instrData,
	output logic dataRead,
	output logic dataWrite,
	output memBusPkg::memAddress dataAddress,
	output memBusPkg::dataWord dataWriteData,
	input wire dataAck,
	input wire memBusPkg::dataWord dataReadData,
	output logic halted
);

	import memBusPkg::*;
	import coreIsaPkg::*;

	localparam memAddress regionBase = memAddress'(coreId) << `REGION_BITS;

	coreState state;
	memAddress pc;
	dataWord acc;
	dataWord instr;
	opcode op;
	operandField operand;
	memAddress target;

	assign op = opcode'(instr[`DATA_WIDTH-1:`OPERAND_BITS]);
	assign operand = instr[`OPERAND_BITS-1:0];
	assign target = regionBase | memAddress'(operand);   // jumps and data stay in region.

	assign instrRead = (state == fetch);
	assign instrAddress = pc;

	assign dataRead = (state == memory) && (op != opStore);
	assign dataWrite = (state == memory) && (op == opStore);
	assign dataAddress = target;
	assign dataWriteData = acc;

	assign halted = (state == coreIsaPkg::halted);

	always_ff @(posedge clk) begin
		if (state == fetch && instrAck) begin
			instr <= instrData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			pc <= '0;
			acc <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= fetch;
					end
				end
				fetch: begin
					if (instrAck) begin
						state <= execute;
					end
				end
				execute: begin
					case (op)
						opLoadImm: begin
							acc <= dataWord'(operand);
							pc <= pc + 1'b1;
							state <= fetch;
						end
						opAddImm: begin
							acc <= acc + dataWord'(operand);
							pc <= pc + 1'b1;
							state <= fetch;
						end
						opJumpNotZero: begin
							pc <= (acc != '0) ? target : pc + 1'b1;
							state <= fetch;
						end
						opHalt: begin
							state <= coreIsaPkg::halted;
						end
						default: begin
							state <= memory;   // load, store, add or xor with memory.
						end
					endcase
				end
				memory: begin
					if (dataAck) begin
						case (op)
							opLoad: acc <= dataReadData;
							opAddMem: acc <= acc + dataReadData;
							opXorMem: acc <= acc ^ dataReadData;
							default: acc <= acc;
						endcase
						pc <= pc + 1'b1;
						state <= fetch;
					end
				end
				default: begin
					state <= state;   // halted until reset.
				end
			endcase
		end
	end

	exclusiveAccess: assert property (@(posedge clk) disable iff (reset)
		!(dataRead && dataWrite));

	// base is fixed by the id, so no access leaves the core's half.
	inOwnRegion: assert property (@(posedge clk) disable iff (reset)
		(dataRead || dataWrite) |-> ((dataAddress >> `REGION_BITS) == memAddress'(coreId)));

endmodule

`default_nettype wire

/* multiCoreTop.sv */
`default_nettype none
`timescale 1ns/10ps

module multiCoreTop (
	input wire clk,
	input wire reset,
	input wire start,
	input wire loadWrite,
	input wire memBusPkg::memAddress loadAddress,
	input wire memBusPkg::dataWord loadData,
	output logic [1:0] ramGrant,
	output logic ramWrite,
	output memBusPkg::memAddress ramAddress,
	output memBusPkg::dataWord ramWriteData,
	output logic [1:0] halted
);

	import memBusPkg::*;

	logic [1:0] instrRead, instrAck;
	memAddress instrAddress0, instrAddress1;
	dataWord instrWord;
	logic instrRamRead;
	memAddress instrRamAddress;
	dataWord instrRamData;

	logic [1:0] dataRead, dataWrite, dataAck;
	memAddress dataAddress0, dataAddress1;
	dataWord dataOut0, dataOut1;
	dataWord dataWord0;
	logic dataRamRead;
	dataWord dataRamData;

	core #(.coreId(1'b0)) core0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.instrRead(instrRead[0]),
		.instrAddress(instrAddress0),
		.instrAck(instrAck[0]),
		.instrData(instrWord),
		.dataRead(dataRead[0]),
		.dataWrite(dataWrite[0]),
		.dataAddress(dataAddress0),
		.dataWriteData(dataOut0),
		.dataAck(dataAck[0]),
		.dataReadData(dataWord0),
		.halted(halted[0])
	);

	core #(.coreId(1'b1)) core1 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.instrRead(instrRead[1]),
		.instrAddress(instrAddress1),
		.instrAck(instrAck[1]),
		.instrData(instrWord),
		.dataRead(dataRead[1]),
		.dataWrite(dataWrite[1]),
		.dataAddress(dataAddress1),
		.dataWriteData(dataOut1),
		.dataAck(dataAck[1]),
		.dataReadData(dataWord0),
		.halted(halted[1])
	);

	// cores never write instructions; the ram is loaded from outside.
	memArbiter instrArbiter (
		.clk(clk),
		.reset(reset),
		.requestRead(instrRead),
		.requestWrite(2'b00),
		.requestAddress({instrAddress1, instrAddress0}),
		.requestData({dataWord'(0), dataWord'(0)}),
		.ack(instrAck),
		.readData(instrWord),
		.grant(),
		.ramRead(instrRamRead),
		.ramWrite(),
		.ramAddress(instrRamAddress),
		.ramWriteData(),
		.ramReadData(instrRamData)
	);

	memArbiter dataArbiter (
		.clk(clk),
		.reset(reset),
		.requestRead(dataRead),
		.requestWrite(dataWrite),
		.requestAddress({dataAddress1, dataAddress0}),
		.requestData({dataOut1, dataOut0}),
		.ack(dataAck),
		.readData(dataWord0),
		.grant(ramGrant),
		.ramRead(dataRamRead),
		.ramWrite(ramWrite),
		.ramAddress(ramAddress),
		.ramWriteData(ramWriteData),
		.ramReadData(dataRamData)
	);

	syncRam instrRam (
		.clk(clk),
		.writeEnable(loadWrite),
		.writeAddress(loadAddress),
		.writeData(loadData),
		.readEnable(instrRamRead),
		.readAddress(instrRamAddress),
		.readData(instrRamData)
	);

	syncRam dataRam (
		.clk(clk),
		.writeEnable(ramWrite),
		.writeAddress(ramAddress),
		.writeData(ramWriteData),
		.readEnable(dataRamRead),
		.readAddress(ramAddress),
		.readData(dataRamData)
	);

endmodule

`default_nettype wire

/* tbMultiCore.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_defs.svh"

module tbMultiCore;

	import memBusPkg::*;
	import coreIsaPkg::*;

	localparam int clockPeriod = 4;
	localparam int rounds = 8;
	localparam int programLength = 24;
	localparam int watchdogCycles = rounds * programLength * 2 * 12
		+ rounds * (10 + 2 * programLength + 8);
	localparam logic [31:0] seedValue = 32'h5c70cd68;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic loadWrite;
	memAddress loadAddress;
	dataWord loadData;
	logic [1:0] ramGrant;
	logic ramWrite;
	memAddress ramAddress;
	dataWord ramWriteData;
	logic [1:0] haltedBits;

	dataWord programWords [2][programLength];
	dataWord modelMem [`RAM_DEPTH];   // both data regions, kept across resets.
	memAddress expAddr [2][programLength];
	dataWord expData [2][programLength];
	int expCount [2];
	int seenCount [2];
	logic [31:0] rngState;
	logic started;
	logic resetWasHigh;
	logic [1:0] haltSeen;
	logic [1:0] prevGrant;
	logic [1:0] idleRequests;   // fetch requests seen while the instruction arbiter idles.
	requesterIndex lastServed;

	multiCoreTop dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.loadWrite(loadWrite),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.ramGrant(ramGrant),
		.ramWrite(ramWrite),
		.ramAddress(ramAddress),
		.ramWriteData(ramWriteData),
		.halted(haltedBits)
	);

	always #(clockPeriod / 2) clk = ~clk;

	always @(posedge clk) begin
		resetWasHigh <= reset;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dataWord encode(input opcode op, input operandField field);
		return {op, field};
	endfunction

	task automatic stopRun();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic reportProblem(input string what);
		$display("%s", what);
		stopRun();
	endtask

	task automatic checkAddress(input string name, input memAddress actual,
			input memAddress expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkData(input string name, input dataWord actual,
			input dataWord expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkFlags(input string name, input logic [1:0] actual,
			input logic [1:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic nextDriveSlot();
		@(posedge clk);
		#1;
	endtask

	// prefix is loadImm 1, jnz 2, so core 1 leaves address 0 for its own half.
	task automatic buildProgram(input int c);
		opcode op;
		operandField operand;
		programWords[c][0] = encode(opLoadImm, operandField'(1));
		programWords[c][1] = encode(opJumpNotZero, operandField'(2));
		for (int p = 2; p < programLength - 1; p++) begin
			rngState = xorshift32(rngState);
			op = opcode'(3'(rngState % 32'd7));
			rngState = xorshift32(rngState);
			if (op == opJumpNotZero) begin
				operand = operandField'(p + 1 + int'(rngState % 32'(programLength - 1 - p)));
			end else if (op == opLoadImm || op == opAddImm) begin
				operand = rngState[`OPERAND_BITS-1:0];
			end else begin
				operand = operandField'(rngState[2:0]);   // few words, so values get reused.
			end
			programWords[c][p] = encode(op, operand);
		end
		programWords[c][programLength-1] = encode(opHalt, operandField'(0));
	endtask

	task automatic runModel(input int c);
		dataWord acc;
		dataWord word;
		int pc;
		opcode op;
		operandField operand;
		memAddress addr;
		logic running;
		acc = '0;
		pc = 0;
		running = 1'b1;
		expCount[c] = 0;
		while (running) begin
			word = programWords[c][pc];
			op = opcode'(word[`DATA_WIDTH-1:`OPERAND_BITS]);
			operand = word[`OPERAND_BITS-1:0];
			addr = memAddress'(c << `REGION_BITS) | memAddress'(operand);
			pc = pc + 1;
			case (op)
				opLoadImm: acc = dataWord'(operand);
				opAddImm: acc = acc + dataWord'(operand);
				opLoad: acc = modelMem[addr];
				opStore: begin
					modelMem[addr] = acc;
					expAddr[c][expCount[c]] = addr;
					expData[c][expCount[c]] = acc;
					expCount[c] = expCount[c] + 1;
				end
				opAddMem: acc = acc + modelMem[addr];
				opXorMem: acc = acc ^ modelMem[addr];
				opJumpNotZero: begin
					if (acc != '0) begin
						pc = int'(operand);   // targets are always ahead.
					end
				end
				default: running = 1'b0;
			endcase
		end
	endtask

	task automatic loadPrograms();
		for (int c = 0; c < 2; c++) begin
			for (int p = 0; p < programLength; p++) begin
				loadWrite = 1'b1;
				loadAddress = memAddress'(c << `REGION_BITS) | memAddress'(p);
				loadData = programWords[c][p];
				nextDriveSlot();
			end
		end
		loadWrite = 1'b0;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		nextDriveSlot();
		started = 1'b0;
		repeat (9) nextDriveSlot();
		reset = 1'b0;
	endtask

	task automatic checkStore();
		int c;
		if (ramGrant != 2'b01 && ramGrant != 2'b10) begin
			reportProblem($sformatf("store seen with ramGrant %b, which is not one-hot", ramGrant));
		end
		c = ramGrant[1] ? 1 : 0;
		if (seenCount[c] >= expCount[c]) begin
			reportProblem($sformatf("core %0d stored more often than the model predicts", c));
		end
		checkAddress($sformatf("ramAddress (core %0d store %0d)", c, seenCount[c]),
			ramAddress, expAddr[c][seenCount[c]]);
		checkData($sformatf("ramWriteData (core %0d store %0d)", c, seenCount[c]),
			ramWriteData, expData[c][seenCount[c]]);
		seenCount[c] = seenCount[c] + 1;
	endtask

	always @(negedge clk) begin
		if (resetWasHigh) begin
			checkFlags("ramGrant", ramGrant, 2'b00);
			checkFlags("ramWrite", {1'b0, ramWrite}, 2'b00);
			checkFlags("halted", haltedBits, 2'b00);
			seenCount[0] = 0;
			seenCount[1] = 0;
			haltSeen = 2'b00;
			prevGrant = 2'b00;
			idleRequests = 2'b00;
			lastServed = 1'b1;   // port 0 wins the first tie.
		end else if (!started) begin
			checkFlags("ramGrant", ramGrant, 2'b00);
			checkFlags("ramWrite", {1'b0, ramWrite}, 2'b00);
			checkFlags("halted", haltedBits, 2'b00);
		end else begin
			if (ramWrite) begin
				checkStore();
			end
			if (dut.instrArbiter.grant == 2'b00) begin
				idleRequests = dut.instrRead;
			end else if (prevGrant == 2'b00) begin
				if (idleRequests == 2'b11 && dut.instrArbiter.grant[1] == lastServed) begin
					reportProblem($sformatf("core %0d was fetched for twice while the other waited",
						dut.instrArbiter.grant[1]));
				end
				lastServed = dut.instrArbiter.grant[1];
			end
			prevGrant = dut.instrArbiter.grant;
			for (int c = 0; c < 2; c++) begin
				if (haltedBits[c] && !haltSeen[c]) begin
					haltSeen[c] = 1'b1;
					if (seenCount[c] != expCount[c]) begin
						reportProblem($sformatf("core %0d halted after %0d stores, model has %0d",
							c, seenCount[c], expCount[c]));
					end
				end else if (!haltedBits[c] && haltSeen[c]) begin
					reportProblem($sformatf("core %0d dropped halted without a reset", c));
				end
			end
		end
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		reportProblem("watchdog expired before all rounds finished");
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		loadWrite = 1'b0;
		loadAddress = '0;
		loadData = '0;
		started = 1'b0;
		rngState = seedValue;
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		for (int round = 0; round < rounds; round++) begin
			applyReset();
			buildProgram(0);
			buildProgram(1);
			runModel(0);
			runModel(1);
			loadPrograms();
			start = 1'b1;
			started = 1'b1;
			nextDriveSlot();
			start = 1'b0;
			do begin
				nextDriveSlot();
			end while (haltedBits != 2'b11);
			repeat (4) nextDriveSlot();   // halted must hold.
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
memBusPkg.sv
coreIsaPkg.sv
syncRam.sv
memArbiter.sv
core.sv
multiCoreTop.sv
tbMultiCore.sv

/* run.sh */
#!/bin/sh
# Compile and run the multi-core testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tbMultiCore -o simMultiCore
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/simMultiCore > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi

echo "simulation passed"
exit 0
